// File: cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
    input  logic           clk,
    input  logic           reset,
    input  logic           int_valid,
    input  logic           mul_valid,
    input  logic           div_valid,
    input  exec_pkg::cdb_t int_res,
    input  exec_pkg::cdb_t mul_res,
    input  exec_pkg::cdb_t div_res,
    output logic           int_grant,
    output logic           mul_grant,
    output logic           div_grant,
    output exec_pkg::cdb_t cdb
);

    logic            valid_q;
    exec_pkg::tag_t  tag_q;
    exec_pkg::word_t value_q;

    // Divider first since it blocks longest, then mul, then int
    assign div_grant = div_valid;
    assign mul_grant = mul_valid && !div_valid;
    assign int_grant = int_valid && !mul_valid && !div_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= div_grant || mul_grant || int_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (div_grant) begin
            tag_q   <= div_res.tag;
            value_q <= div_res.value;
        end else if (mul_grant) begin
            tag_q   <= mul_res.tag;
            value_q <= mul_res.value;
        end else if (int_grant) begin
            tag_q   <= int_res.tag;
            value_q <= int_res.value;
        end
    end

    assign cdb = {valid_q, tag_q, value_q};

endmodule

// File: dispatch_router.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module dispatch_router (
    input  logic                disp_valid,
    input  exec_pkg::dispatch_t disp,
    input  logic                rs_full_int,
    input  logic                rs_full_mul,
    input  logic                rs_full_div,
    output logic                wr_int,
    output logic                wr_mul,
    output logic                wr_div,
    output exec_pkg::dispatch_t wr_entry,
    output logic                disp_stall
);

    logic sel_int;
    logic sel_mul;
    logic sel_div;

    assign sel_mul = (disp.opcode == `OPC_MUL);
    assign sel_div = (disp.opcode == `OPC_DIV);
    assign sel_int = !sel_mul && !sel_div;     // Everything else is add class

    // Stall follows the target station of the opcode on the bus
    assign disp_stall = (sel_int && rs_full_int) || (sel_mul && rs_full_mul) ||
                        (sel_div && rs_full_div);

    assign wr_int = disp_valid && sel_int && !disp_stall;
    assign wr_mul = disp_valid && sel_mul && !disp_stall;
    assign wr_div = disp_valid && sel_div && !disp_stall;

    always_comb begin
        wr_entry = disp;
        if (disp.use_imm) begin
            wr_entry.src2_tag   = '0;
            wr_entry.src2_ready = 1'b1;          // Immediate never waits
            wr_entry.src2_value = disp.imm;
        end
    end

endmodule

// File: div_unit.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module div_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    input  logic             grant,
    output logic             unit_ready,
    output logic             res_valid,
    output exec_pkg::cdb_t   res
);

    exec_pkg::div_state_e state_q;
    logic [5:0]           count_q;
    exec_pkg::word_t      quo_q;       // Dividend shifts out, quotient shifts in
    exec_pkg::word_t      rem_q;
    exec_pkg::word_t      dvs_q;
    exec_pkg::func3_t     f3_q;
    exec_pkg::tag_t       tag_q;
    exec_pkg::word_t      value_q;
    logic [32:0]          rem_shift;
    logic [32:0]          diff;
    logic                 fits;

    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, dvs_q};
    assign fits      = (rem_shift >= {1'b0, dvs_q});

    assign unit_ready = (state_q == exec_pkg::div_idle);
    assign res_valid  = (state_q == exec_pkg::div_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= exec_pkg::div_idle;
        end else begin
            case (state_q)
                exec_pkg::div_idle: if (issue_valid) state_q <= exec_pkg::div_busy;
                exec_pkg::div_busy: if (count_q == 6'd32) state_q <= exec_pkg::div_done;
                exec_pkg::div_done: if (grant) state_q <= exec_pkg::div_idle;
                default:            state_q <= exec_pkg::div_idle;
            endcase
        end
    end

    // Divisor zero always fits, giving all ones and the dividend as remainder
    always_ff @(posedge clk) begin
        if (state_q == exec_pkg::div_idle && issue_valid) begin
            quo_q   <= issue.op1;
            dvs_q   <= issue.op2;
            rem_q   <= '0;
            count_q <= '0;
            f3_q    <= issue.func3;
            tag_q   <= issue.rd_tag;
        end else if (state_q == exec_pkg::div_busy) begin
            count_q <= count_q + 6'd1;
            if (count_q == 6'd32) begin
                case (f3_q)
                    `F3_REMU: value_q <= rem_q;
                    `F3_DIVU: value_q <= quo_q;
                    default:  value_q <= quo_q;
                endcase
            end else begin
                rem_q <= fits ? diff[31:0] : rem_shift[31:0];
                quo_q <= {quo_q[30:0], fits};
            end
        end
    end

    assign res = {res_valid, tag_q, value_q};

endmodule

// File: exec_cluster.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module exec_cluster (
    input  logic                clk,
    input  logic                reset,
    input  logic                disp_valid,
    input  exec_pkg::dispatch_t disp,
    output logic                disp_stall,
    output exec_pkg::cdb_t      cdb
);

    exec_pkg::dispatch_t wr_entry;
    logic                wr_int, wr_mul, wr_div;
    logic                full_int, full_mul, full_div;
    logic                iv_int, iv_mul, iv_div;      // Station issue valids
    exec_pkg::issue_t    is_int, is_mul, is_div;
    logic                rdy_int, rdy_mul, rdy_div;   // Unit ready levels
    logic                rv_int, rv_mul, rv_div;
    exec_pkg::cdb_t      res_int, res_mul, res_div;
    logic                gnt_int, gnt_mul, gnt_div;

    dispatch_router router0 (
        .disp_valid(disp_valid), .disp(disp),
        .rs_full_int(full_int), .rs_full_mul(full_mul), .rs_full_div(full_div),
        .wr_int(wr_int), .wr_mul(wr_mul), .wr_div(wr_div),
        .wr_entry(wr_entry), .disp_stall(disp_stall)
    );

    reservation_station #(.DEPTH(`RS_DEPTH)) rs_int (
        .clk(clk), .reset(reset), .wr(wr_int), .wr_entry(wr_entry), .cdb(cdb),
        .unit_ready(rdy_int), .full(full_int), .issue_valid(iv_int), .issue(is_int)
    );

    reservation_station #(.DEPTH(`RS_DEPTH)) rs_mul (
        .clk(clk), .reset(reset), .wr(wr_mul), .wr_entry(wr_entry), .cdb(cdb),
        .unit_ready(rdy_mul), .full(full_mul), .issue_valid(iv_mul), .issue(is_mul)
    );

    reservation_station #(.DEPTH(`RS_DEPTH)) rs_div (
        .clk(clk), .reset(reset), .wr(wr_div), .wr_entry(wr_entry), .cdb(cdb),
        .unit_ready(rdy_div), .full(full_div), .issue_valid(iv_div), .issue(is_div)
    );

    int_unit int_unit0 (
        .clk(clk), .reset(reset), .issue_valid(iv_int), .issue(is_int), .grant(gnt_int),
        .unit_ready(rdy_int), .res_valid(rv_int), .res(res_int)
    );

    mul_unit mul_unit0 (
        .clk(clk), .reset(reset), .issue_valid(iv_mul), .issue(is_mul), .grant(gnt_mul),
        .unit_ready(rdy_mul), .res_valid(rv_mul), .res(res_mul)
    );

    div_unit div_unit0 (
        .clk(clk), .reset(reset), .issue_valid(iv_div), .issue(is_div), .grant(gnt_div),
        .unit_ready(rdy_div), .res_valid(rv_div), .res(res_div)
    );

    cdb_arbiter arb0 (
        .clk(clk), .reset(reset),
        .int_valid(rv_int), .mul_valid(rv_mul), .div_valid(rv_div),
        .int_res(res_int), .mul_res(res_mul), .div_res(res_div),
        .int_grant(gnt_int), .mul_grant(gnt_mul), .div_grant(gnt_div),
        .cdb(cdb)
    );

endmodule

// File: exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define OPC_MUL     7'b0110011  // Routed to the multiply station
`define OPC_DIV     7'b1001111  // Routed to the divide station

`define F3_ADD      3'd0
`define F3_SLTU     3'd3
`define F3_XOR      3'd4
`define F3_OR       3'd6
`define F3_AND      3'd7
`define F3_MULLO    3'd0        // Low half of the product
`define F3_MULHU    3'd3        // High half, unsigned
`define F3_DIVU     3'd5
`define F3_REMU     3'd7

`define RS_DEPTH    4           // Entries per reservation station
`define MUL_STAGES  3           // Multiplier pipeline depth

`endif

// File: exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;    // Operand and result data
    typedef logic [7:0]  tag_t;     // Physical register tag
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  func3_t;

    // Renamed instruction as it arrives from dispatch
    typedef struct packed {
        opcode_t opcode;
        func3_t  func3;
        logic    use_imm;       // Second source comes from imm
        word_t   imm;
        tag_t    rd_tag;
        tag_t    src1_tag;
        logic    src1_ready;
        word_t   src1_value;
        tag_t    src2_tag;
        logic    src2_ready;
        word_t   src2_value;
    } dispatch_t;

    // Operation handed from a station to its functional unit
    typedef struct packed {
        func3_t func3;
        word_t  op1;
        word_t  op2;
        tag_t   rd_tag;
    } issue_t;

    // Common data bus beat and unit result
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;
    } cdb_t;

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_e;

endpackage

// File: int_unit.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module int_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    input  logic             grant,
    output logic             unit_ready,
    output logic             res_valid,
    output exec_pkg::cdb_t   res
);

    exec_pkg::word_t result;
    exec_pkg::word_t value_q;
    exec_pkg::tag_t  tag_q;

    always_comb begin
        case (issue.func3)
            `F3_SLTU: result = {31'b0, issue.op1 < issue.op2};
            `F3_XOR:  result = issue.op1 ^ issue.op2;
            `F3_OR:   result = issue.op1 | issue.op2;
            `F3_AND:  result = issue.op1 & issue.op2;
            `F3_ADD:  result = issue.op1 + issue.op2;
            default:  result = issue.op1 + issue.op2;   // Unused codes add
        endcase
    end

    assign unit_ready = !res_valid || grant;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (issue_valid && unit_ready) begin
            res_valid <= 1'b1;
        end else if (grant) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && unit_ready) begin
            value_q <= result;
            tag_q   <= issue.rd_tag;
        end
    end

    assign res = {res_valid, tag_q, value_q};

endmodule

// File: mul_unit.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module mul_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             issue_valid,
    input  exec_pkg::issue_t issue,
    input  logic             grant,
    output logic             unit_ready,
    output logic             res_valid,
    output exec_pkg::cdb_t   res
);

    logic [`MUL_STAGES-1:0] vld_q;     // One valid bit per stage
    logic                   advance;
    exec_pkg::word_t        a_q;
    exec_pkg::word_t        b_q;
    exec_pkg::func3_t       f3_1_q;
    exec_pkg::func3_t       f3_2_q;
    exec_pkg::tag_t         tag_1_q;
    exec_pkg::tag_t         tag_2_q;
    exec_pkg::tag_t         tag_3_q;
    logic [63:0]            prod_q;
    exec_pkg::word_t        value_q;

    // Whole pipe freezes while the last stage waits for the bus
    assign advance    = !(res_valid && !grant);
    assign unit_ready = advance;
    assign res_valid  = vld_q[`MUL_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q <= {vld_q[`MUL_STAGES-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            a_q     <= issue.op1;              // Stage one
            b_q     <= issue.op2;
            f3_1_q  <= issue.func3;
            tag_1_q <= issue.rd_tag;
            prod_q  <= 64'(a_q) * 64'(b_q);    // Stage two
            f3_2_q  <= f3_1_q;
            tag_2_q <= tag_1_q;
            tag_3_q <= tag_2_q;                // Stage three
            case (f3_2_q)
                `F3_MULHU: value_q <= prod_q[63:32];
                `F3_MULLO: value_q <= prod_q[31:0];
                default:   value_q <= prod_q[31:0];
            endcase
        end
    end

    assign res = {res_valid, tag_3_q, value_q};

endmodule

// File: reservation_station.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module reservation_station #(
    parameter int DEPTH = `RS_DEPTH
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr,
    input  exec_pkg::dispatch_t wr_entry,
    input  exec_pkg::cdb_t      cdb,
    input  logic                unit_ready,
    output logic                full,
    output logic                issue_valid,
    output exec_pkg::issue_t    issue
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    exec_pkg::dispatch_t slot_q [DEPTH];
    logic [DEPTH-1:0]    busy_q;
    logic [DEPTH-1:0]    rdy;
    logic [IW-1:0]       free_idx;
    logic [IW-1:0]       sel_idx;
    logic                sel_found;
    logic                issue_load;

    // Capture a broadcast value into any source still waiting on its tag
    function automatic exec_pkg::dispatch_t snoop(exec_pkg::dispatch_t e,
                                                  exec_pkg::cdb_t b);
        exec_pkg::dispatch_t r;
        r = e;
        if (b.valid && !e.src1_ready && (e.src1_tag == b.tag)) begin
            r.src1_ready = 1'b1;
            r.src1_value = b.value;
        end
        if (b.valid && !e.src2_ready && (e.src2_tag == b.tag)) begin
            r.src2_ready = 1'b1;
            r.src2_value = b.value;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            rdy[i] = busy_q[i] && slot_q[i].src1_ready && slot_q[i].src2_ready;
        end
    end

    // Walk downwards so the lowest index wins
    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        sel_found = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_idx = IW'(i);
            end
            if (rdy[i]) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
            end
        end
    end

    assign full       = &busy_q;
    assign issue_load = sel_found && (!issue_valid || unit_ready);  // Empty or draining

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (wr) begin
                busy_q[free_idx] <= 1'b1;
            end
            if (issue_load) begin
                busy_q[sel_idx] <= 1'b0;           // Slot freed as it moves out
                issue_valid     <= 1'b1;
            end else if (unit_ready) begin
                issue_valid     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_q[i] <= snoop(slot_q[i], cdb);
        end
        if (wr) begin
            slot_q[free_idx] <= snoop(wr_entry, cdb);  // Wakeup on the dispatch cycle too
        end
        if (issue_load) begin
            issue.func3  <= slot_q[sel_idx].func3;
            issue.op1    <= slot_q[sel_idx].src1_value;
            issue.op2    <= slot_q[sel_idx].src2_value;
            issue.rd_tag <= slot_q[sel_idx].rd_tag;
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_exec_cluster -o tb_exec_cluster \
    && ./obj_dir/tb_exec_cluster | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sim.f
+incdir+.
exec_pkg.sv
dispatch_router.sv
reservation_station.sv
int_unit.sv
mul_unit.sv
div_unit.sv
cdb_arbiter.sv
exec_cluster.sv
tb_exec_cluster.sv

// File: tb_exec_cluster.sv
`timescale 1ns/100ps
`include "exec_consts.svh"

module tb_exec_cluster;

    localparam int max_cycles = 3000;            // About five times the longest run of all tests
    localparam logic [6:0] opc_int = 7'b0010011; // Any opcode outside mul and div

    logic                clk;
    logic                reset;
    logic                disp_valid;
    exec_pkg::dispatch_t disp;
    logic                disp_stall;
    exec_pkg::cdb_t      cdb;

    exec_pkg::word_t exp_val [256];              // Expected result by rd tag
    logic            exp_live [256];             // Tag was dispatched
    int              seen_cnt [256];
    int              seen_seq [256];             // Bus order of each tag
    int              issued;
    int              results_seen;
    int              cycle_cnt;
    exec_pkg::tag_t  next_tag;
    string           test_name;

    exec_cluster dut0 (
        .clk(clk), .reset(reset), .disp_valid(disp_valid), .disp(disp),
        .disp_stall(disp_stall), .cdb(cdb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= max_cycles) begin
                stop_run($sformatf("Timeout after %0d cycles in %s", cycle_cnt, test_name));
            end
        end
    end

    // Bus monitor that checks every broadcast against the reference model
    always @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                seen_cnt[i] = 0;
                seen_seq[i] = 0;
            end
            results_seen = 0;
        end else if (cdb.valid) begin
            assert (exp_live[cdb.tag] && seen_cnt[cdb.tag] == 0) else
                stop_run($sformatf("Unexpected or repeated tag %0d on the bus in %s",
                                   cdb.tag, test_name));
            assert (cdb.value == exp_val[cdb.tag]) else
                stop_run($sformatf("FAILED %s tag %0d expected %h actual %h",
                                   test_name, cdb.tag, exp_val[cdb.tag], cdb.value));
            seen_cnt[cdb.tag] = seen_cnt[cdb.tag] + 1;
            results_seen      = results_seen + 1;
            seen_seq[cdb.tag] = results_seen;
        end
    end

    function automatic exec_pkg::word_t int_ref(input exec_pkg::func3_t f3,
                                                input exec_pkg::word_t a,
                                                input exec_pkg::word_t b);
        case (f3)
            `F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:  return a ^ b;
            `F3_OR:   return a | b;
            `F3_AND:  return a & b;
            default:  return a + b;
        endcase
    endfunction

    function automatic exec_pkg::word_t mul_ref(input exec_pkg::func3_t f3,
                                                input exec_pkg::word_t a,
                                                input exec_pkg::word_t b);
        logic [63:0] p;
        p = {32'b0, a} * {32'b0, b};
        return (f3 == `F3_MULHU) ? p[63:32] : p[31:0];
    endfunction

    // Zero divisor gives all ones and the dividend back
    function automatic exec_pkg::word_t div_ref(input exec_pkg::func3_t f3,
                                                input exec_pkg::word_t a,
                                                input exec_pkg::word_t b);
        if (b == 32'd0) begin
            return (f3 == `F3_REMU) ? a : 32'hffff_ffff;
        end
        return (f3 == `F3_REMU) ? a % b : a / b;
    endfunction

    function automatic exec_pkg::dispatch_t ready_op(input logic [6:0] opc,
                                                     input exec_pkg::func3_t f3,
                                                     input exec_pkg::tag_t rd,
                                                     input exec_pkg::word_t a,
                                                     input exec_pkg::word_t b);
        exec_pkg::dispatch_t d;
        d            = '0;
        d.opcode     = opc;
        d.func3      = f3;
        d.rd_tag     = rd;
        d.src1_ready = 1'b1;
        d.src1_value = a;
        d.src2_ready = 1'b1;
        d.src2_value = b;
        return d;
    endfunction

    // Strobes one packet, records its expected result and moves next_tag on
    task automatic dispatch_op(input exec_pkg::dispatch_t d, input exec_pkg::word_t expected);
        @(posedge clk);
        disp       <= d;
        disp_valid <= 1'b1;
        exp_val[d.rd_tag]  = expected;
        exp_live[d.rd_tag] = 1'b1;
        issued   = issued + 1;
        next_tag = next_tag + 8'd1;
        @(negedge clk);
        assert (!disp_stall) else
            stop_run($sformatf("Dispatch of tag %0d stalled in %s", d.rd_tag, test_name));
    endtask

    task automatic wait_results();
        @(posedge clk);
        disp_valid <= 1'b0;
        while (results_seen != issued) @(posedge clk);
        repeat (4) @(posedge clk);               // Room for a stray repeat to show up
    endtask

    task automatic int_op_results();
        exec_pkg::func3_t    ops [5];
        exec_pkg::word_t     a;
        exec_pkg::word_t     b;
        exec_pkg::dispatch_t d;
        ops       = '{`F3_ADD, `F3_SLTU, `F3_XOR, `F3_OR, `F3_AND};
        test_name = "int_ops";
        for (int i = 0; i < 5; i++) begin
            a = $urandom;
            b = $urandom;
            dispatch_op(ready_op(opc_int, ops[i], next_tag, a, b), int_ref(ops[i], a, b));
            d            = ready_op(opc_int, ops[i], next_tag, a, 32'hdead_beef);
            d.src2_ready = 1'b0;                 // Imm must replace a waiting source
            d.src2_tag   = 8'hfe;
            d.use_imm    = 1'b1;
            d.imm        = b;
            dispatch_op(d, int_ref(ops[i], a, b));
            wait_results();
        end
        dispatch_op(ready_op(opc_int, `F3_SLTU, next_tag, 32'd5, 32'hffff_ffff), 32'd1);
        dispatch_op(ready_op(opc_int, `F3_SLTU, next_tag, 32'hffff_ffff, 32'd5), 32'd0);
        wait_results();
    endtask

    task automatic mul_products();
        exec_pkg::word_t  a;
        exec_pkg::word_t  b;
        exec_pkg::func3_t f3;
        test_name = "mul_ops";
        a = $urandom;
        b = $urandom;
        dispatch_op(ready_op(`OPC_MUL, `F3_MULLO, next_tag, a, b), mul_ref(`F3_MULLO, a, b));
        dispatch_op(ready_op(`OPC_MUL, `F3_MULHU, next_tag, a, b), mul_ref(`F3_MULHU, a, b));
        dispatch_op(ready_op(`OPC_MUL, `F3_MULHU, next_tag, 32'hffff_ffff, 32'hffff_ffff),
                    32'hffff_fffe);
        wait_results();
        test_name = "mul_back_to_back";
        for (int i = 0; i < 3; i++) begin
            a  = $urandom;
            b  = $urandom;
            f3 = (i == 1) ? `F3_MULHU : `F3_MULLO;
            dispatch_op(ready_op(`OPC_MUL, f3, next_tag, a, b), mul_ref(f3, a, b));
        end
        wait_results();
    endtask

    task automatic div_results();
        exec_pkg::word_t a;
        exec_pkg::word_t b;
        test_name = "div_ops";
        a = $urandom;
        b = $urandom >> 12;                      // Keep the quotient away from zero
        dispatch_op(ready_op(`OPC_DIV, `F3_DIVU, next_tag, a, b), div_ref(`F3_DIVU, a, b));
        dispatch_op(ready_op(`OPC_DIV, `F3_REMU, next_tag, a, b), div_ref(`F3_REMU, a, b));
        wait_results();
        dispatch_op(ready_op(`OPC_DIV, `F3_DIVU, next_tag, 32'd100, 32'd7), 32'd14);
        dispatch_op(ready_op(`OPC_DIV, `F3_REMU, next_tag, 32'd100, 32'd7), 32'd2);
        wait_results();
        test_name = "div_by_zero";
        dispatch_op(ready_op(`OPC_DIV, `F3_DIVU, next_tag, a, 32'd0), 32'hffff_ffff);
        dispatch_op(ready_op(`OPC_DIV, `F3_REMU, next_tag, a, 32'd0), a);
        wait_results();
    endtask

    task automatic dependent_add();
        exec_pkg::tag_t      div_tag;
        exec_pkg::tag_t      add_tag;
        exec_pkg::dispatch_t d;
        test_name = "dependency_chain";
        div_tag   = next_tag;
        dispatch_op(ready_op(`OPC_DIV, `F3_DIVU, div_tag, 32'd1000, 32'd7),
                    div_ref(`F3_DIVU, 32'd1000, 32'd7));
        add_tag      = next_tag;
        d            = ready_op(opc_int, `F3_ADD, add_tag, 32'd0, 32'd58);
        d.src1_ready = 1'b0;                     // Waits on the divide result
        d.src1_tag   = div_tag;
        dispatch_op(d, div_ref(`F3_DIVU, 32'd1000, 32'd7) + 32'd58);
        wait_results();
        assert (seen_seq[add_tag] > seen_seq[div_tag]) else
            stop_run("Dependent add reached the bus before the divide it waits on");
    endtask

    task automatic full_station_stall();
        exec_pkg::tag_t      tags [7];
        exec_pkg::dispatch_t d;
        exec_pkg::word_t     pend_val;
        test_name = "mixed_stall";
        pend_val  = div_ref(`F3_REMU, 32'd1000, 32'd7);
        tags[0]   = next_tag;
        dispatch_op(ready_op(`OPC_DIV, `F3_REMU, tags[0], 32'd1000, 32'd7), pend_val);
        for (int i = 1; i < 5; i++) begin
            tags[i]      = next_tag;
            d            = ready_op(opc_int, `F3_ADD, tags[i], 32'd0, 32'(i * 16));
            d.src1_ready = 1'b0;
            d.src1_tag   = tags[0];
            dispatch_op(d, pend_val + 32'(i * 16));
        end
        tags[5] = next_tag;                      // Mul class still gets in
        dispatch_op(ready_op(`OPC_MUL, `F3_MULLO, tags[5], 32'd12, 32'd11), 32'd132);
        tags[6] = next_tag;
        d       = ready_op(opc_int, `F3_OR, tags[6], 32'h0000_00f0, 32'h0000_0f00);
        @(posedge clk);
        disp       <= d;
        disp_valid <= 1'b0;
        @(negedge clk);
        assert (disp_stall) else
            stop_run("disp_stall is low while the add station is full");
        while (disp_stall) @(negedge clk);
        dispatch_op(d, int_ref(`F3_OR, 32'h0000_00f0, 32'h0000_0f00));
        wait_results();
    endtask

    initial begin
        void'($urandom(32'h23d4));
        reset      <= 1'b1;
        disp_valid <= 1'b0;
        disp       <= '0;
        issued    = 0;
        next_tag  = 8'd1;
        test_name = "reset";
        for (int i = 0; i < 256; i++) begin
            exp_live[i] = 1'b0;
            exp_val[i]  = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!disp_stall && !cdb.valid) else
            stop_run("Stall or bus valid is high right after reset");
        int_op_results();
        mul_products();
        div_results();
        dependent_add();
        full_station_stall();
        $display("TESTS PASSED");
        $finish;
    end

endmodule
